// ==== fetch_top.f ====
rtl/fetch_pkg.sv
rtl/thread_pc.sv
rtl/fetch_stage.sv
rtl/fetch_queue.sv
rtl/decode_stage.sv
rtl/fetch_top.sv
testbench/fetch_top_assertions.sv
testbench/fetch_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f fetch_top.f \
	--top-module fetch_top_tb \
	-Mdir obj_dir \
	-o fetch_top_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/fetch_top_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// ==== testbench/fetch_top_tb.sv ====
//////////////////////////////
// testbench for the fetch front end
// memory model, stimulus table, per-thread scoreboard
//////////////////////////////
`timescale 1ns/1ps

module fetch_top_tb;
	import fetch_pkg::*;

	localparam addr_t start_pc      = 64'h0000_0000_0001_0000;
	localparam int    num_rows      = 8;
	localparam int    settle_cycles = 8;	// leftovers of the previous row drain by then

	typedef struct packed {
		logic       two_threads;
		logic [1:0] stall;
		int         dr_pct;	// dispatch_ready probability in percent
		logic       redir_en;
		thread_id_t redir_thread;
		addr_t      redir_target;
		int         redir_cycle;
		logic       imem_random;
		int         cycles;
		int         mode;	// 0 free, 1 strict alternation, 2 thread 0 only
	} row_t;

	logic                clock;
	logic                reset;
	logic                two_threads;
	logic [1:0]          thread_stall;
	redirect_t           redirect;
	addr_t               imem_addr;
	logic [63:0]         imem_data;
	logic                imem_valid;
	decoded_inst_t [1:0] decoded;
	logic                dispatch_ready;

	row_t       rows [num_rows];
	addr_t      exp_pc [2];	// next expected slot 0 address per thread
	int         result_count [2];
	thread_id_t last_seen;
	integer     seed;
	int         cycle_count = 0;
	int         cycle_limit;

	fetch_top #(
		.reset_pc(start_pc),
		.queue_depth(4)
	) DUT (
		.clock(clock),
		.reset(reset),
		.two_threads(two_threads),
		.thread_stall(thread_stall),
		.redirect(redirect),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.imem_valid(imem_valid),
		.decoded(decoded),
		.dispatch_ready(dispatch_ready)
	);

	always #4 clock = ~clock;

	//////////////////////////////
	// instruction memory model
	//////////////////////////////
	function automatic inst_word_t mem_word(input addr_t addr);
		inst_word_t  w;
		logic [31:0] mix;
		mix = addr[63:32] ^ addr[31:0] ^ {addr[15:0], addr[31:16]};
		if (addr[3:2] == 2'b11)
		begin
			w.branch.opcode = op_branch;	// every fourth word
			w.branch.ra     = mix[8:4];
			w.branch.disp   = {{12{mix[10]}}, mix[10:2]};
		end
		else
		begin
			w.operate.opcode = {2'b00, addr[5:2]};
			w.operate.ra     = mix[12:8];
			w.operate.rb     = mix[17:13];
			w.operate.func   = mix[28:18];
			w.operate.rc     = mix[6:2] ^ mix[23:19];
		end
		return w;
	endfunction

	assign imem_data = {mem_word(imem_addr + 64'd4), mem_word(imem_addr)};

	// expected decode of one slot from the encoding rules
	function automatic decoded_inst_t expect_slot(input addr_t pc, input thread_id_t t);
		inst_word_t    w;
		decoded_inst_t d;
		w        = mem_word(pc);
		d        = '0;
		d.valid  = 1'b1;
		d.thread = t;
		d.pc     = pc;
		if (w.branch.opcode == op_branch)
		begin
			d.is_branch     = 1'b1;
			d.dest_reg      = w.branch.ra;
			d.branch_target = pc + 64'd4 + addr_t'(longint'($signed(w.branch.disp)) * 4);
		end
		else
		begin
			d.dest_reg = w.operate.rc;
		end
		return d;
	endfunction

	function automatic logic chance(input int pct);
		int roll;
		roll = $unsigned($random(seed)) % 100;
		return roll < pct;
	endfunction

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic check_decoded(input string name, input decoded_inst_t expected,
		input decoded_inst_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			$display("Verification failed");
			$fatal(1, "decoded result differs from the expected one");
		end
	endtask

	task automatic check_thread(input string name, input thread_id_t expected,
		input thread_id_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
			$display("Verification failed");
			$fatal(1, "decoded thread differs from the expected one");
		end
	endtask

	// one consumed decode result against the thread's own address stream
	task automatic score_result();
		thread_id_t t;
		t = decoded[0].thread;
		check_decoded("decoded[0]", expect_slot(exp_pc[t], t), decoded[0]);
		check_decoded("decoded[1]", expect_slot(exp_pc[t] + 64'd4, t), decoded[1]);
		exp_pc[t]       = exp_pc[t] + 64'd8;
		result_count[t] = result_count[t] + 1;
		last_seen       = t;
	endtask

	task automatic load_table();
		// two_threads, stall, dr %, redirect on, thread, target, at cycle, random imem, cycles, mode
		rows[0] = '{1'b0, 2'b00, 100, 1'b0, 1'b0, 64'h0, 0, 1'b0, 30, 2};
		rows[1] = '{1'b1, 2'b00, 100, 1'b0, 1'b0, 64'h0, 0, 1'b0, 40, 1};
		rows[2] = '{1'b1, 2'b10, 100, 1'b0, 1'b0, 64'h0, 0, 1'b0, 30, 2};
		rows[3] = '{1'b1, 2'b00, 100, 1'b0, 1'b0, 64'h0, 0, 1'b1, 40, 0};
		rows[4] = '{1'b1, 2'b00, 100, 1'b1, 1'b1, 64'h0000_0000_0003_0a3c, 10, 1'b0, 40, 0};
		rows[5] = '{1'b1, 2'b00, 50, 1'b1, 1'b0, 64'h0000_0000_0000_8004, 25, 1'b1, 120, 0};
		rows[6] = '{1'b1, 2'b01, 60, 1'b0, 1'b0, 64'h0, 0, 1'b1, 60, 0};
		rows[7] = '{1'b1, 2'b00, 100, 1'b0, 1'b0, 64'h0, 0, 1'b0, 40, 0};
	endtask

	// runaway guard
	always @(posedge clock)
	begin
		if (!reset)
			cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("stimulus did not finish within %0d cycles", cycle_limit);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// stimulus and scoring
	//////////////////////////////
	initial
	begin
		logic ready;
		logic fire_redirect;
		seed            = 32'h7a39_190c;
		clock           = 1'b0;
		reset           = 1'b1;
		two_threads     = 1'b0;
		thread_stall    = 2'b00;
		redirect        = '0;
		imem_valid      = 1'b1;	// memory already answers while reset is held
		dispatch_ready  = 1'b0;
		exp_pc[0]       = start_pc;
		exp_pc[1]       = start_pc;
		result_count[0] = 0;
		result_count[1] = 0;
		last_seen       = 1'b1;	// matches the last fetched thread after reset
		load_table();
		cycle_limit = 200;
		for (int r = 0; r < num_rows; r++)
			cycle_limit = cycle_limit + rows[r].cycles;

		repeat (16) @(negedge clock);
		reset = 1'b0;

		for (int r = 0; r < num_rows; r++)
		begin
			for (int c = 0; c < rows[r].cycles; c++)
			begin
				fire_redirect = rows[r].redir_en && (c == rows[r].redir_cycle);
				ready         = fire_redirect || chance(rows[r].dr_pct);	// drain decode on redirect
				if (ready && (decoded[0].valid || decoded[1].valid))
				begin
					if (c >= settle_cycles && rows[r].mode == 1)
						check_thread("decoded[0].thread", ~last_seen, decoded[0].thread);
					else if (c >= settle_cycles && rows[r].mode == 2)
						check_thread("decoded[0].thread", 1'b0, decoded[0].thread);
					score_result();
				end
				if (fire_redirect)
					exp_pc[rows[r].redir_thread] = rows[r].redir_target & ~64'd7;

				two_threads     = rows[r].two_threads;
				thread_stall    = rows[r].stall;
				redirect.valid  = fire_redirect;
				redirect.thread = rows[r].redir_thread;
				redirect.target = rows[r].redir_target;
				imem_valid      = rows[r].imem_random ? chance(80) : 1'b1;
				dispatch_ready  = ready;
				@(negedge clock);
			end
		end

		if (result_count[0] > 0 && result_count[1] > 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
		begin
			$display("a thread produced no decoded results");
			$display("Verification failed");
			$fatal(1, "missing results");
		end
	end

endmodule

// ==== testbench/fetch_top_assertions.sv ====
//////////////////////////////
// fetch stage assertions
// reset quiet, stalled pcs held, aligned fetch address
//////////////////////////////
`timescale 1ns/1ps

module fetch_top_assertions (
	input logic                 clock,
	input logic                 reset,
	input logic                 push_valid,
	input logic [1:0]           thread_stall,
	input fetch_pkg::redirect_t redirect,
	input fetch_pkg::addr_t     thread0_pc,
	input fetch_pkg::addr_t     thread1_pc,
	input fetch_pkg::addr_t     imem_addr
);

	// quiet in reset and in the first cycle after it
	a_no_push_in_reset: assert property (@(posedge clock) reset |=> !push_valid)
		else $error("push_valid high during or right after reset");

	// a push would step the pc of a stalled thread
	a_stalled_pc0_held: assert property (@(posedge clock) disable iff (reset)
		thread_stall[0] && !(redirect.valid && redirect.thread == 1'b0)
		|=> $stable(thread0_pc))
		else $error("thread 0 pc moved while thread 0 was stalled");

	a_stalled_pc1_held: assert property (@(posedge clock) disable iff (reset)
		thread_stall[1] && !(redirect.valid && redirect.thread == 1'b1)
		|=> $stable(thread1_pc))
		else $error("thread 1 pc moved while thread 1 was stalled");

	a_aligned_addr: assert property (@(posedge clock) disable iff (reset)
		imem_addr[2:0] == 3'b000)	// whole instruction pairs only
		else $error("imem_addr not 8 byte aligned");

endmodule

bind fetch_stage fetch_top_assertions u_assertions (
	.clock(clock),
	.reset(reset),
	.push_valid(push_valid),
	.thread_stall(thread_stall),
	.redirect(redirect),
	.thread0_pc(pcs[0]),
	.thread1_pc(pcs[1]),
	.imem_addr(imem_addr)
);

// ==== rtl/fetch_top.sv ====
//////////////////////////////
// fetch front end top
// fetch stage, fetch queue and decode stage in a row
//////////////////////////////
`timescale 1ns/1ps

module fetch_top #(
	parameter fetch_pkg::addr_t reset_pc    = '0,
	parameter int               queue_depth = 4
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           two_threads,
	input  logic [1:0]                     thread_stall,
	input  fetch_pkg::redirect_t           redirect,
	output fetch_pkg::addr_t               imem_addr,
	input  logic [63:0]                    imem_data,
	input  logic                           imem_valid,
	output fetch_pkg::decoded_inst_t [1:0] decoded,
	input  logic                           dispatch_ready
);
	import fetch_pkg::*;

	logic          push_valid;
	logic          push_ready;
	fetch_bundle_t push_bundle;
	logic          pop_valid;
	logic          pop_ready;
	fetch_bundle_t pop_bundle;

	fetch_stage #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clock(clock),
		.reset(reset),
		.two_threads(two_threads),
		.thread_stall(thread_stall),
		.redirect(redirect),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.imem_valid(imem_valid),
		.push_valid(push_valid),
		.push_bundle(push_bundle),
		.push_ready(push_ready)
	);

	fetch_queue #(
		.queue_depth(queue_depth)
	) u_queue (
		.clock(clock),
		.reset(reset),
		.push_valid(push_valid),
		.push_bundle(push_bundle),
		.push_ready(push_ready),
		.pop_valid(pop_valid),
		.pop_bundle(pop_bundle),
		.pop_ready(pop_ready),
		.redirect(redirect)
	);

	decode_stage u_decode (
		.clock(clock),
		.reset(reset),
		.pop_valid(pop_valid),
		.pop_bundle(pop_bundle),
		.pop_ready(pop_ready),
		.decoded(decoded),
		.dispatch_ready(dispatch_ready)
	);

endmodule

// ==== rtl/decode_stage.sv ====
//////////////////////////////
// decode stage
// splits both slots of a bundle and holds them for dispatch
//////////////////////////////
`timescale 1ns/1ps

module decode_stage (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           pop_valid,
	input  fetch_pkg::fetch_bundle_t       pop_bundle,
	output logic                           pop_ready,
	output fetch_pkg::decoded_inst_t [1:0] decoded,
	input  logic                           dispatch_ready
);
	import fetch_pkg::*;

	logic [1:0]          valid_q;
	decoded_inst_t [1:0] slot_q;	// payload of the output register
	decoded_inst_t [1:0] slot_next;
	logic                do_pop;

	function automatic decoded_inst_t decode_slot(
		input inst_word_t word,
		input addr_t      pc,
		input thread_id_t thread,
		input logic       live
	);
		decoded_inst_t d;
		addr_t         offset;
		offset      = {{41{word.branch.disp[20]}}, word.branch.disp, 2'b00};
		d.valid     = live;
		d.thread    = thread;
		d.pc        = pc;
		d.is_branch = (word.branch.opcode == op_branch);
		if (d.is_branch)
		begin
			d.dest_reg      = word.branch.ra;
			d.branch_target = pc + 64'd4 + offset;
		end
		else
		begin
			d.dest_reg      = word.operate.rc;
			d.branch_target = '0;
		end
		return d;
	endfunction

	assign pop_ready = !(|valid_q) || dispatch_ready;	// empty or draining
	assign do_pop    = pop_valid && pop_ready;

	always_comb
	begin
		slot_next[0] = decode_slot(pop_bundle.inst[0], pop_bundle.pc,
			pop_bundle.thread, !pop_bundle.killed);
		slot_next[1] = decode_slot(pop_bundle.inst[1], pop_bundle.pc + 64'd4,
			pop_bundle.thread, !pop_bundle.killed);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			valid_q <= '0;
		else if (do_pop)
			valid_q <= {slot_next[1].valid, slot_next[0].valid};
		else if (dispatch_ready)
			valid_q <= '0;	// taken downstream, nothing new
	end

	always_ff @(posedge clock)
	begin
		if (do_pop)
			slot_q <= slot_next;
	end

	always_comb
	begin
		decoded          = slot_q;
		decoded[0].valid = valid_q[0];
		decoded[1].valid = valid_q[1];
	end

endmodule

// ==== rtl/fetch_queue.sv ====
//////////////////////////////
// fetch queue
// circular FIFO of bundles, kills entries of a redirected thread
//////////////////////////////
`timescale 1ns/1ps

module fetch_queue #(
	parameter int queue_depth = 4
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     push_valid,
	input  fetch_pkg::fetch_bundle_t push_bundle,
	output logic                     push_ready,
	output logic                     pop_valid,
	output fetch_pkg::fetch_bundle_t pop_bundle,
	input  logic                     pop_ready,
	input  fetch_pkg::redirect_t     redirect
);
	import fetch_pkg::*;

	localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w = $clog2(queue_depth + 1);

	fetch_bundle_t    entries [queue_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             do_push;
	logic             do_pop;

	// wraps at any depth, not only powers of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(queue_depth - 1))
			return '0;
		else
			return p + 1'b1;
	endfunction

	assign push_ready = (count != cnt_w'(queue_depth));
	assign pop_valid  = (count != '0);
	assign do_push    = push_valid && push_ready;
	assign do_pop     = pop_valid && pop_ready;

	always_comb
	begin
		pop_bundle = entries[rd_ptr];
		// a head leaving on the redirect edge is already stale
		if (redirect.valid && (pop_bundle.thread == redirect.thread))
			pop_bundle.killed = 1'b1;
	end

	//////////////////////////////
	// pointers and count
	//////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
		end
	end

	// storage, the new entry overrides any kill on its slot
	always_ff @(posedge clock)
	begin
		if (redirect.valid)
		begin
			for (int i = 0; i < queue_depth; i++)
			begin
				if (entries[i].thread == redirect.thread)
					entries[i].killed <= 1'b1;
			end
		end
		if (do_push)
			entries[wr_ptr] <= push_bundle;
	end

endmodule

// ==== rtl/fetch_stage.sv ====
//////////////////////////////
// fetch stage
// picks a thread, reads one instruction pair, pushes a bundle
//////////////////////////////
`timescale 1ns/1ps

module fetch_stage #(
	parameter fetch_pkg::addr_t reset_pc = '0
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     two_threads,
	input  logic [1:0]               thread_stall,
	input  fetch_pkg::redirect_t     redirect,
	output fetch_pkg::addr_t         imem_addr,
	input  logic [63:0]              imem_data,
	input  logic                     imem_valid,
	output logic                     push_valid,
	output fetch_pkg::fetch_bundle_t push_bundle,
	input  logic                     push_ready
);
	import fetch_pkg::*;

	thread_id_t last_thread;	// thread of the last pushed bundle
	thread_id_t cand_thread;
	thread_id_t sel_thread;
	logic       fetch_on;
	logic       sel_redirect;
	logic       push_fire;
	logic [1:0] advance;
	logic [1:0] thread_redirect;
	addr_t      pcs [2];

	//////////////////////////////
	// one pc per thread
	//////////////////////////////
	for (genvar t = 0; t < 2; t++)
	begin : g_thread
		assign thread_redirect[t] = redirect.valid && (redirect.thread == thread_id_t'(t));
		assign advance[t]         = push_fire && (sel_thread == thread_id_t'(t));

		thread_pc #(
			.reset_pc(reset_pc)
		) u_pc (
			.clock(clock),
			.reset(reset),
			.advance(advance[t]),
			.redirect_valid(thread_redirect[t]),
			.redirect_target(redirect.target),
			.pc(pcs[t])
		);
	end

	//////////////////////////////
	// thread select
	//////////////////////////////
	always_comb
	begin
		cand_thread = ~last_thread;	// round robin candidate
		if (!two_threads)
			sel_thread = 1'b0;
		else if (thread_stall[cand_thread])
			sel_thread = last_thread;
		else
			sel_thread = cand_thread;
	end

	assign imem_addr    = pcs[sel_thread];
	assign sel_redirect = redirect.valid && (redirect.thread == sel_thread);

	// a redirected thread drops its fetch this cycle
	assign push_valid = fetch_on && imem_valid && !thread_stall[sel_thread] && !sel_redirect;
	assign push_fire  = push_valid && push_ready;

	always_comb
	begin
		push_bundle.thread = sel_thread;
		push_bundle.killed = 1'b0;
		push_bundle.pc     = imem_addr;
		push_bundle.inst   = imem_data;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			last_thread <= 1'b1;	// so thread 0 goes first
			fetch_on    <= 1'b0;
		end
		else
		begin
			fetch_on <= 1'b1;	// fetch starts the cycle after reset
			if (push_fire)
				last_thread <= sel_thread;
		end
	end

endmodule

// ==== rtl/thread_pc.sv ====
//////////////////////////////
// per-thread fetch pc
// holds, steps by one bundle, or loads a redirect target
//////////////////////////////
`timescale 1ns/1ps

module thread_pc #(
	parameter fetch_pkg::addr_t reset_pc = '0
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             advance,
	input  logic             redirect_valid,
	input  fetch_pkg::addr_t redirect_target,
	output fetch_pkg::addr_t pc
);

	logic [63:0] aligned_target;

	// fetch always works on whole 8 byte pairs
	assign aligned_target = {redirect_target[63:3], 3'b000};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= reset_pc;
		end
		else if (redirect_valid)
		begin
			pc <= aligned_target;	// redirect wins over advance
		end
		else if (advance)
		begin
			pc <= pc + 64'd8;
		end
	end

endmodule

// ==== rtl/fetch_pkg.sv ====
//////////////////////////////
// fetch front end types
// bundles, redirects, the two instruction formats and decode results
//////////////////////////////
package fetch_pkg;

	typedef logic [63:0] addr_t;
	typedef logic        thread_id_t;

	localparam logic [5:0] op_branch = 6'h30;	// opcode of the branch format

	// operate format, three registers
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [10:0] func;
		logic [4:0]  rc;
	} operate_fmt_t;

	typedef struct packed {
		logic [5:0]         opcode;
		logic [4:0]         ra;
		logic signed [20:0] disp;	// in words, relative to pc + 4
	} branch_fmt_t;

	typedef union packed {
		operate_fmt_t operate;
		branch_fmt_t  branch;
	} inst_word_t;

	typedef struct packed {
		thread_id_t       thread;
		logic             killed;
		addr_t            pc;	// slot 0 address
		inst_word_t [1:0] inst;	// slot 0 in the low word
	} fetch_bundle_t;

	typedef struct packed {
		logic       valid;
		thread_id_t thread;
		addr_t      target;
	} redirect_t;

	typedef struct packed {
		logic       valid;
		thread_id_t thread;
		addr_t      pc;
		logic       is_branch;
		logic [4:0] dest_reg;
		addr_t      branch_target;	// zero for operate
	} decoded_inst_t;

endpackage
